/* hazard.f */
logic/isaPkg.sv
logic/pipePkg.sv
logic/instrDecoder.sv
logic/stageTracker.sv
logic/stallUnit.sv
logic/mduControl.sv
logic/mduTimer.sv
logic/hazardTop.sv
test/hazardTb.sv

/* logic/hazardTop.sv */
module hazardTop #(
    parameter int MultCycles = 5,
    parameter int DivCycles  = 10,
    parameter int TimerWidth = 4
) (
    input  logic              clk,
    input  logic              rstN,
    input  isaPkg::instrWordT instrD,
    output logic              stall,
    output logic              mduBusy
);
    import pipePkg::*;

    regIdxT                useRs;
    regIdxT                useRt;
    stageTimeT             tuseRs;
    stageTimeT             tuseRt;
    regIdxT                dstD;
    stageTimeT             tnewD;
    mduClassT              mduD;
    regIdxT                dstE;
    stageTimeT             tnewE;
    mduClassT              mduE;
    regIdxT                dstM;
    stageTimeT             tnewM;
    logic                  mduStart;
    logic                  timerLoad;
    logic [TimerWidth-1:0] timerCount;
    logic                  timerDone;

    ////////////////////////////////////////////////////////////
    // Decode and stage tracking
    ////////////////////////////////////////////////////////////
    instrDecoder decoder0 (
        .instr  (instrD),
        .useRs  (useRs),
        .useRt  (useRt),
        .tuseRs (tuseRs),
        .tuseRt (tuseRt),
        .dst    (dstD),
        .tnew   (tnewD),
        .mdu    (mduD)
    );

    stageTracker tracker0 (
        .clk   (clk),
        .rstN  (rstN),
        .stall (stall),
        .dstD  (dstD),
        .tnewD (tnewD),
        .mduD  (mduD),
        .dstE  (dstE),
        .tnewE (tnewE),
        .mduE  (mduE),
        .dstM  (dstM),
        .tnewM (tnewM)
    );

    stallUnit stall0 (
        .useRs    (useRs),
        .useRt    (useRt),
        .tuseRs   (tuseRs),
        .tuseRt   (tuseRt),
        .dstE     (dstE),
        .tnewE    (tnewE),
        .dstM     (dstM),
        .tnewM    (tnewM),
        .mduD     (mduD),
        .mduStart (mduStart),
        .mduBusy  (mduBusy),
        .stall    (stall)
    );

    ////////////////////////////////////////////////////////////
    // Multiply/divide sequencer
    ////////////////////////////////////////////////////////////
    mduControl #(
        .MultCycles (MultCycles),
        .DivCycles  (DivCycles),
        .TimerWidth (TimerWidth)
    ) mduCtrl0 (
        .clk        (clk),
        .rstN       (rstN),
        .mduE       (mduE),
        .timerDone  (timerDone),
        .mduStart   (mduStart),
        .mduBusy    (mduBusy),
        .timerLoad  (timerLoad),
        .timerCount (timerCount)
    );

    mduTimer #(
        .TimerWidth (TimerWidth)
    ) timer0 (
        .clk        (clk),
        .rstN       (rstN),
        .timerLoad  (timerLoad),
        .timerCount (timerCount),
        .timerDone  (timerDone)
    );

endmodule

/* logic/instrDecoder.sv */
module instrDecoder (
    input  isaPkg::instrWordT  instr,
    output pipePkg::regIdxT    useRs,
    output pipePkg::regIdxT    useRt,
    output pipePkg::stageTimeT tuseRs,
    output pipePkg::stageTimeT tuseRt,
    output pipePkg::regIdxT    dst,
    output pipePkg::stageTimeT tnew,
    output pipePkg::mduClassT  mdu
);
    import isaPkg::*;
    import pipePkg::*;

    always_comb begin
        useRs  = '0;
        useRt  = '0;
        tuseRs = '0;
        tuseRt = '0;
        dst    = '0;
        tnew   = '0;
        mdu    = mduNone;
        case (instr.r.opcode)
            opR: begin
                case (instr.r.funct)
                    fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu: begin
                        useRs  = instr.r.rs;
                        useRt  = instr.r.rt;
                        tuseRs = 2'd1;
                        tuseRt = 2'd1;
                        dst    = instr.r.rd;
                        tnew   = 2'd1;
                    end
                    fnMult, fnMultu, fnDiv, fnDivu: begin
                        useRs  = instr.r.rs;
                        useRt  = instr.r.rt;
                        tuseRs = 2'd1;
                        tuseRt = 2'd1;
                        mdu    = (instr.r.funct == fnDiv || instr.r.funct == fnDivu) ?
                                 mduDiv : mduMult;
                    end
                    fnMthi, fnMtlo: begin
                        useRs  = instr.r.rs;
                        tuseRs = 2'd1;
                        mdu    = mduHilo;
                    end
                    fnMfhi, fnMflo: begin
                        dst  = instr.r.rd;
                        tnew = 2'd1;
                        mdu  = mduHilo;
                    end
                    // Jump target needed in decode
                    fnJr: useRs = instr.r.rs;
                    default: ;
                endcase
            end
            opOri, opAddi, opAndi: begin
                useRs  = instr.i.rs;
                tuseRs = 2'd1;
                dst    = instr.i.rt;
                tnew   = 2'd1;
            end
            opLui: begin
                dst  = instr.i.rt;
                tnew = 2'd1;
            end
            opLw, opLb, opLh: begin
                useRs  = instr.i.rs;
                tuseRs = 2'd1;
                dst    = instr.i.rt;
                tnew   = 2'd2;
            end
            opSw, opSb, opSh: begin
                useRs  = instr.i.rs;
                useRt  = instr.i.rt;
                tuseRs = 2'd1;
                tuseRt = 2'd2;
            end
            // Compared in decode, so both at Tuse 0
            opBeq, opBne: begin
                useRs = instr.i.rs;
                useRt = instr.i.rt;
            end
            // Link address is ready at once
            opJal: dst = 5'd31;
            opJ: ;
            default: ;
        endcase
    end

endmodule

/* logic/isaPkg.sv */
package isaPkg;

    // Primary opcodes
    localparam logic [5:0] opR    = 6'h00;
    localparam logic [5:0] opJ    = 6'h02;
    localparam logic [5:0] opJal  = 6'h03;
    localparam logic [5:0] opBeq  = 6'h04;
    localparam logic [5:0] opBne  = 6'h05;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opAndi = 6'h0c;
    localparam logic [5:0] opOri  = 6'h0d;
    localparam logic [5:0] opLui  = 6'h0f;
    localparam logic [5:0] opLb   = 6'h20;
    localparam logic [5:0] opLh   = 6'h21;
    localparam logic [5:0] opLw   = 6'h23;
    localparam logic [5:0] opSb   = 6'h28;
    localparam logic [5:0] opSh   = 6'h29;
    localparam logic [5:0] opSw   = 6'h2b;

    // Function field of R-type words
    localparam logic [5:0] fnJr    = 6'h08;
    localparam logic [5:0] fnMfhi  = 6'h10;
    localparam logic [5:0] fnMthi  = 6'h11;
    localparam logic [5:0] fnMflo  = 6'h12;
    localparam logic [5:0] fnMtlo  = 6'h13;
    localparam logic [5:0] fnMult  = 6'h18;
    localparam logic [5:0] fnMultu = 6'h19;
    localparam logic [5:0] fnDiv   = 6'h1a;
    localparam logic [5:0] fnDivu  = 6'h1b;
    localparam logic [5:0] fnAdd   = 6'h20;
    localparam logic [5:0] fnSub   = 6'h22;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnSlt   = 6'h2a;
    localparam logic [5:0] fnSltu  = 6'h2b;

    // Same 32 bits in register or immediate form
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
    } instrWordT;

endpackage

/* logic/mduControl.sv */
module mduControl #(
    parameter int MultCycles = 5,
    parameter int DivCycles  = 10,
    parameter int TimerWidth = 4
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  pipePkg::mduClassT     mduE,
    input  logic                  timerDone,
    output logic                  mduStart,
    output logic                  mduBusy,
    output logic                  timerLoad,
    output logic [TimerWidth-1:0] timerCount
);
    import pipePkg::*;

    localparam logic Idle = 1'b0;
    localparam logic Busy = 1'b1;

    logic state;

    assign mduStart   = (state == Idle) && (mduE == mduMult || mduE == mduDiv);
    assign timerLoad  = mduStart;
    assign timerCount = (mduE == mduDiv) ? TimerWidth'(DivCycles) : TimerWidth'(MultCycles);
    assign mduBusy    = (state == Busy);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: if (mduStart) state <= Busy;
                Busy: if (timerDone) state <= Idle;
                default: state <= Idle;
            endcase
        end
    end

endmodule

/* logic/mduTimer.sv */
module mduTimer #(
    parameter int TimerWidth = 4
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  timerLoad,
    input  logic [TimerWidth-1:0] timerCount,
    output logic                  timerDone
);

    logic [TimerWidth-1:0] count;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (timerLoad) begin
            count <= timerCount;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Last busy cycle
    assign timerDone = (count == TimerWidth'(1));

endmodule

/* logic/pipePkg.sv */
package pipePkg;

    // Register number where zero means no register
    typedef logic [4:0] regIdxT;

    // Cycles until a value is needed or produced
    typedef logic [1:0] stageTimeT;

    // What an instruction asks of the multiply/divide unit
    typedef enum logic [1:0] {
        mduNone = 2'd0,
        mduMult = 2'd1,
        mduDiv  = 2'd2,
        mduHilo = 2'd3
    } mduClassT;

endpackage

/* logic/stageTracker.sv */
module stageTracker (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  pipePkg::regIdxT    dstD,
    input  pipePkg::stageTimeT tnewD,
    input  pipePkg::mduClassT  mduD,
    output pipePkg::regIdxT    dstE,
    output pipePkg::stageTimeT tnewE,
    output pipePkg::mduClassT  mduE,
    output pipePkg::regIdxT    dstM,
    output pipePkg::stageTimeT tnewM
);
    import pipePkg::*;

    stageTimeT tnewAged;

    // One cycle closer to the result
    assign tnewAged = (tnewE == '0) ? '0 : stageTimeT'(tnewE - 2'd1);

    ////////////////////////////////////////////////////////////
    // Execute stage record
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dstE  <= '0;
            tnewE <= '0;
            mduE  <= mduNone;
        end else if (stall) begin
            dstE  <= '0;
            tnewE <= '0;
            mduE  <= mduNone;
        end else begin
            dstE  <= dstD;
            tnewE <= tnewD;
            mduE  <= mduD;
        end
    end

    ////////////////////////////////////////////////////////////
    // Memory stage record that advances even during a stall
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dstM  <= '0;
            tnewM <= '0;
        end else begin
            dstM  <= dstE;
            tnewM <= tnewAged;
        end
    end

endmodule

/* logic/stallUnit.sv */
module stallUnit (
    input  pipePkg::regIdxT    useRs,
    input  pipePkg::regIdxT    useRt,
    input  pipePkg::stageTimeT tuseRs,
    input  pipePkg::stageTimeT tuseRt,
    input  pipePkg::regIdxT    dstE,
    input  pipePkg::stageTimeT tnewE,
    input  pipePkg::regIdxT    dstM,
    input  pipePkg::stageTimeT tnewM,
    input  pipePkg::mduClassT  mduD,
    input  logic               mduStart,
    input  logic               mduBusy,
    output logic               stall
);
    import pipePkg::*;

    logic rsHazE;
    logic rsHazM;
    logic rtHazE;
    logic rtHazM;
    logic mduHaz;

    // Forwarding cannot help when the value is needed sooner than produced
    assign rsHazE = (useRs != '0) && (useRs == dstE) && (tuseRs < tnewE);
    assign rsHazM = (useRs != '0) && (useRs == dstM) && (tuseRs < tnewM);
    assign rtHazE = (useRt != '0) && (useRt == dstE) && (tuseRt < tnewE);
    assign rtHazM = (useRt != '0) && (useRt == dstM) && (tuseRt < tnewM);

    // HI/LO access or a new operation waits for the unit
    assign mduHaz = (mduD != mduNone) && (mduStart || mduBusy);

    assign stall = rsHazE || rsHazM || rtHazE || rtHazM || mduHaz;

endmodule

/* run.sh */
#!/bin/sh
# Build the hazard-control testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module hazardTb -f hazard.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VhazardTb 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
    exit 0
fi
exit 1

/* test/hazardTb.sv */
module hazardTb;
    import isaPkg::*;
    import pipePkg::*;

    localparam int ClkPeriod      = 40;
    localparam int ResetCycles    = 10;
    localparam int MultCycles     = 5;
    localparam int DivCycles      = 10;
    localparam int DirectedCycles = 200;
    localparam int RandomCycles   = 1500;

    // Row layout {rs read, rs Tuse, rt read, rt Tuse, dst field, Tnew, MDU class}
    localparam logic [2:0] Skip  = 3'b000;
    localparam logic [2:0] Tuse0 = 3'b100;
    localparam logic [2:0] Tuse1 = 3'b101;
    localparam logic [2:0] Tuse2 = 3'b110;
    localparam logic [1:0] SelNone = 2'd0;
    localparam logic [1:0] SelRd   = 2'd1;
    localparam logic [1:0] SelRt   = 2'd2;
    localparam logic [1:0] Sel31   = 2'd3;

    logic        clk;
    logic        rstN;
    instrWordT   instrD;
    logic        stall;
    logic        mduBusy;

    // Shadow execute and memory records
    regIdxT      expDstE;
    stageTimeT   expTnewE;
    mduClassT    expMduE;
    regIdxT      expDstM;
    stageTimeT   expTnewM;
    int          busyLeft;
    logic        expStart;
    logic        expStall;
    logic        expBusy;

    // Word in decode as the shadow model reads it
    logic [11:0] dRow;
    regIdxT      dRs;
    regIdxT      dRt;
    regIdxT      dDst;

    logic [31:0] lfsr;
    instrWordT   prog[$];

    hazardTop dut0 (
        .clk     (clk),
        .rstN    (rstN),
        .instrD  (instrD),
        .stall   (stall),
        .mduBusy (mduBusy)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Instruction builders and random source
    ////////////////////////////////////////////////////////////
    function automatic instrWordT rWord(input logic [5:0] fn, input regIdxT rs,
                                        input regIdxT rt, input regIdxT rd);
        instrWordT w;
        w.r = '{opR, rs, rt, rd, 5'd0, fn};
        return w;
    endfunction

    function automatic instrWordT iWord(input logic [5:0] op, input regIdxT rs,
                                        input regIdxT rt, input logic [15:0] imm);
        instrWordT w;
        w.i = '{op, rs, rt, imm};
        return w;
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic instrWordT randomInstr();
        logic [9:0] v;
        regIdxT     a;
        regIdxT     b;
        regIdxT     c;
        v = '0;
        repeat (10) begin
            lfsr = lfsrNext(lfsr);
            v = {v[8:0], lfsr[0]};
        end
        // Registers 0 to 3 only, so hazards come often
        a = {3'd0, v[5:4]};
        b = {3'd0, v[3:2]};
        c = {3'd0, v[1:0]};
        case (v[9:6])
            4'd0:    return rWord(fnAdd, a, b, c);
            4'd1:    return rWord(fnSltu, a, b, c);
            4'd2:    return iWord(opOri, a, b, 16'h00ff);
            4'd3:    return iWord(opLui, a, b, 16'h8000);
            4'd4:    return iWord(opLw, a, b, 16'h0010);
            4'd5:    return iWord(opLh, a, b, 16'h0002);
            4'd6:    return iWord(opSw, a, b, 16'h0010);
            4'd7:    return iWord(opBeq, a, b, 16'hfffc);
            4'd8:    return iWord(opBne, a, b, 16'h0004);
            4'd9:    return rWord(fnJr, a, 5'd0, 5'd0);
            4'd10:   return rWord(fnMult, a, b, 5'd0);
            4'd11:   return rWord(fnDivu, a, b, 5'd0);
            4'd12:   return rWord(fnMfhi, 5'd0, 5'd0, c);
            4'd13:   return rWord(fnMtlo, a, 5'd0, 5'd0);
            4'd14:   return iWord(opJal, 5'd0, 5'd0, 16'h0040);
            default: return rWord(6'h00, a, b, c);
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Shadow model
    ////////////////////////////////////////////////////////////
    function automatic logic [11:0] rowOf(input instrWordT w);
        if (w.r.opcode == opR) begin
            case (w.r.funct)
                fnAdd, fnSub, fnAnd,
                fnOr, fnSlt, fnSltu: return {Tuse1, Tuse1, SelRd, 2'd1, mduNone};
                fnMult, fnMultu:     return {Tuse1, Tuse1, SelNone, 2'd0, mduMult};
                fnDiv, fnDivu:       return {Tuse1, Tuse1, SelNone, 2'd0, mduDiv};
                fnMthi, fnMtlo:      return {Tuse1, Skip, SelNone, 2'd0, mduHilo};
                fnMfhi, fnMflo:      return {Skip, Skip, SelRd, 2'd1, mduHilo};
                fnJr:                return {Tuse0, Skip, SelNone, 2'd0, mduNone};
                default:             return {Skip, Skip, SelNone, 2'd0, mduNone};
            endcase
        end
        case (w.i.opcode)
            opOri, opAddi, opAndi: return {Tuse1, Skip, SelRt, 2'd1, mduNone};
            opLui:                 return {Skip, Skip, SelRt, 2'd1, mduNone};
            opLw, opLb, opLh:      return {Tuse1, Skip, SelRt, 2'd2, mduNone};
            opSw, opSb, opSh:      return {Tuse1, Tuse2, SelNone, 2'd0, mduNone};
            opBeq, opBne:          return {Tuse0, Tuse0, SelNone, 2'd0, mduNone};
            opJal:                 return {Skip, Skip, Sel31, 2'd0, mduNone};
            default:               return {Skip, Skip, SelNone, 2'd0, mduNone};
        endcase
    endfunction

    function automatic logic waitsFor(input regIdxT r, input stageTimeT tuse,
                                      input regIdxT dst, input stageTimeT tnew);
        return r != 5'd0 && r == dst && tuse < tnew;
    endfunction

    always_comb begin
        dRow = rowOf(instrD);
        dRs  = dRow[11] ? instrD.r.rs : 5'd0;
        dRt  = dRow[8] ? instrD.r.rt : 5'd0;
        case (dRow[5:4])
            SelRd:   dDst = instrD.r.rd;
            SelRt:   dDst = instrD.i.rt;
            Sel31:   dDst = 5'd31;
            default: dDst = 5'd0;
        endcase
        expStart = busyLeft == 0 && (expMduE == mduMult || expMduE == mduDiv);
        expBusy  = busyLeft != 0;
        expStall = waitsFor(dRs, dRow[10:9], expDstE, expTnewE)
                || waitsFor(dRs, dRow[10:9], expDstM, expTnewM)
                || waitsFor(dRt, dRow[7:6], expDstE, expTnewE)
                || waitsFor(dRt, dRow[7:6], expDstM, expTnewM)
                || (dRow[1:0] != mduNone && (expStart || expBusy));
    end

    always @(posedge clk) begin
        if (!rstN) begin
            expDstE  <= '0;
            expTnewE <= '0;
            expMduE  <= mduNone;
            expDstM  <= '0;
            expTnewM <= '0;
            busyLeft <= 0;
        end else begin
            expDstM  <= expDstE;
            expTnewM <= (expTnewE == 2'd0) ? 2'd0 : expTnewE - 2'd1;
            // Bubble into execute while decode waits
            expDstE  <= expStall ? 5'd0 : dDst;
            expTnewE <= expStall ? 2'd0 : dRow[3:2];
            expMduE  <= expStall ? mduNone : mduClassT'(dRow[1:0]);
            if (expStart) begin
                busyLeft <= (expMduE == mduDiv) ? DivCycles : MultCycles;
            end else if (busyLeft != 0) begin
                busyLeft <= busyLeft - 1;
            end
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    stallCheck: assert property (@(negedge clk) disable iff (!rstN) stall == expStall)
        else abortRun($sformatf("Error at %0t: stall expected %0b, actual %0b",
                                $time, expStall, stall));

    busyCheck: assert property (@(negedge clk) disable iff (!rstN) mduBusy == expBusy)
        else abortRun($sformatf("Error at %0t: mduBusy expected %0b, actual %0b",
                                $time, expBusy, mduBusy));

    initial begin
        #((DirectedCycles + RandomCycles + 50) * ClkPeriod);
        abortRun("Timeout: the stimulus did not finish within its cycle budget");
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    task automatic queueDirected();
        repeat (3) prog.push_back('0);
        // Load then use, store of the loaded value, ALU chain
        prog.push_back(iWord(opLw, 5'd2, 5'd1, 16'h0004));
        prog.push_back(rWord(fnAdd, 5'd1, 5'd2, 5'd3));
        prog.push_back(iWord(opLw, 5'd2, 5'd1, 16'h0008));
        prog.push_back(iWord(opSw, 5'd2, 5'd1, 16'h000c));
        prog.push_back(rWord(fnAdd, 5'd2, 5'd3, 5'd4));
        prog.push_back(rWord(fnSub, 5'd4, 5'd4, 5'd5));
        // Branch and jr right behind their producer
        prog.push_back(rWord(fnOr, 5'd1, 5'd2, 5'd6));
        prog.push_back(iWord(opBeq, 5'd6, 5'd0, 16'h0010));
        prog.push_back(iWord(opLw, 5'd2, 5'd7, 16'h0000));
        prog.push_back(iWord(opBne, 5'd1, 5'd7, 16'h0010));
        prog.push_back(rWord(fnSlt, 5'd1, 5'd2, 5'd8));
        prog.push_back(rWord(fnJr, 5'd8, 5'd0, 5'd0));
        // Register zero on both sides
        prog.push_back(iWord(opLw, 5'd2, 5'd0, 16'h0000));
        prog.push_back(rWord(fnAdd, 5'd0, 5'd0, 5'd9));
        prog.push_back(iWord(opLui, 5'd0, 5'd0, 16'h1234));
        prog.push_back(iWord(opBeq, 5'd0, 5'd0, 16'h0000));
        // MDU latency, HI/LO access and back-to-back operations
        prog.push_back(rWord(fnMult, 5'd1, 5'd2, 5'd0));
        prog.push_back(rWord(fnMfhi, 5'd0, 5'd0, 5'd3));
        prog.push_back(rWord(fnMultu, 5'd3, 5'd2, 5'd0));
        prog.push_back(rWord(fnMult, 5'd1, 5'd1, 5'd0));
        prog.push_back(rWord(fnDiv, 5'd1, 5'd2, 5'd0));
        prog.push_back(rWord(fnMflo, 5'd0, 5'd0, 5'd4));
        prog.push_back(rWord(fnDivu, 5'd2, 5'd1, 5'd0));
        repeat (DivCycles + 2) prog.push_back('0);
        prog.push_back(rWord(fnMthi, 5'd4, 5'd0, 5'd0));
    endtask

    initial begin
        logic held;
        clk    = 1'b0;
        rstN   = 1'b0;
        instrD = '0;
        lfsr   = 32'h15fe;
        held   = 1'b0;
        queueDirected();
        repeat (ResetCycles) @(posedge clk);
        #2;
        rstN = 1'b1;
        // Directed words first, random ones once the queue is empty
        for (int c = 0; c < DirectedCycles + RandomCycles; c++) begin
            if (!held) begin
                if (prog.size() != 0) begin
                    instrD = prog.pop_front();
                end else begin
                    instrD = randomInstr();
                end
            end
            @(negedge clk);
            held = stall;
            @(posedge clk);
            #2;
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule
